// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_st_master
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: project.f
src/st_link_pkg.sv
src/link_tx_if.sv
src/stream_pack.sv
src/link_auto_sync.sv
src/link_transmit.sv
src/phy_lane_map.sv
src/st_master_top.sv
sim/tb_clock.sv
sim/st_master_properties.sv
sim/tb_st_master.sv

// File: sim/st_master_properties.sv
/* Transmitter handshake rules */

module st_master_properties (
  input logic                  clk_wr,
  input logic                  rst_n,
  input logic                  link_up,
  input logic                  beat_valid,
  input logic                  beat_pop,
  input st_link_pkg::st_beat_t beat
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far
  int failures = 0;

  // Held beat waits for its pop unchanged
  a_beat_held : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    beat_valid && !beat_pop |=> beat_valid && $stable(beat)
  ) else begin
    failures++;
    $error("held beat lost or changed before its pop");
  end

  // Input stage takes nothing while the link is down
  a_closed_while_down : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    !link_up && !beat_valid |=> !beat_valid
  ) else begin
    failures++;
    $error("beat accepted while the link was down");
  end

endmodule

// File: sim/tb_clock.sv
/* Testbench clock and reset */

module tb_clock (
  output logic clk_wr,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  // Reset held for 5 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk_wr);
    #1 rst_n = 1'b1;
  end

endmodule

// File: sim/tb_st_master.sv
/* Stream link master testbench */

module tb_st_master;

  timeunit 1ns;
  timeprecision 1ps;

  import st_link_pkg::*;

  localparam int CRED_W  = 8;
  localparam int DELAY_W = 16;
  localparam int DX      = 4;
  localparam int DY      = 3;
  localparam int DZ      = 5;
  localparam int NUM     = 12;
  localparam int LIMIT   = 60;

  // One table row: beat fields plus credit handed back before it
  typedef struct packed {
    logic [TDATA_W-1:0]    tdata;
    logic [TKEEP_W-1:0]    tkeep;
    logic [TUSER_W-1:0]    tuser;
    logic [CRED_RET_W-1:0] ret;
  } entry_t;

  logic                 clk_wr;
  logic                 rst_n;
  logic                 tx_online;
  logic                 rx_online;
  logic [CRED_W-1:0]    init_st_credit;
  logic [1:0]           tx_mrk_userbit;
  logic [DELAY_W-1:0]   delay_x_value;
  logic [DELAY_W-1:0]   delay_y_value;
  logic [DELAY_W-1:0]   delay_z_value;
  logic [TDATA_W-1:0]   user_tdata;
  logic [TKEEP_W-1:0]   user_tkeep;
  logic [TUSER_W-1:0]   user_tuser;
  logic                 user_tvalid;
  logic                 user_tready;
  logic [LANE_W-1:0]    tx_phy0;
  logic [LANE_W-1:0]    tx_phy1;
  logic [LANE_W-1:0]    rx_phy0;
  logic [LANE_W-1:0]    rx_phy1;

  entry_t   tbl [NUM];
  st_beat_t rx_q [$];
  st_beat_t lane_beat;
  int       seed;
  int       errors;
  int       checks;

  tb_clock u_clock (.clk_wr(clk_wr), .rst_n(rst_n));

  st_master_top #(.CRED_W(CRED_W), .DELAY_W(DELAY_W)) uut (
    .clk_wr(clk_wr), .rst_n(rst_n),
    .tx_online(tx_online), .rx_online(rx_online),
    .init_st_credit(init_st_credit), .tx_mrk_userbit(tx_mrk_userbit),
    .delay_x_value(delay_x_value), .delay_y_value(delay_y_value),
    .delay_z_value(delay_z_value),
    .user_tdata(user_tdata), .user_tkeep(user_tkeep), .user_tuser(user_tuser),
    .user_tvalid(user_tvalid), .user_tready(user_tready),
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1), .rx_phy0(rx_phy0), .rx_phy1(rx_phy1)
  );

  bind link_transmit st_master_properties u_props (
    .clk_wr(clk_wr), .rst_n(rst_n), .link_up(link_up),
    .beat_valid(beat_valid), .beat_pop(beat_pop), .beat(beat)
  );

  //////////////////////////////
  // Lane monitor
  //////////////////////////////

  // Rebuild a beat from both lanes on each push bit
  always @(negedge clk_wr) begin
    if (rst_n && tx_phy1[PUSH_BIT]) begin
      lane_beat = {tx_phy1[SLICE_W-1:0], tx_phy0[SLICE_W-1:0]};
      rx_q.push_back(lane_beat);
    end
  end

  //////////////////////////////
  // Checks and helpers
  //////////////////////////////

  // Field order tuser, tkeep, tdata
  function automatic st_beat_t expect_beat(input int i);
    st_beat_t b;
    b.tuser = tbl[i].tuser;
    b.tkeep = tbl[i].tkeep;
    b.tdata = tbl[i].tdata;
    return b;
  endfunction

  task automatic check_beat(input string name, input st_beat_t got, input st_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge clk_wr);
    #1;
  endtask

  task automatic wait_ready(output int n);
    n = 0;
    while (!user_tready && n < LIMIT) begin
      @(posedge clk_wr);
      #1;
      n++;
    end
    if (!user_tready) begin
      errors++;
      $display("user_tready did not rise within %0d cycles", LIMIT);
    end
  endtask

  task automatic wait_pushes(input int want);
    int c;
    c = 0;
    while (rx_q.size() < want && c < LIMIT) begin
      @(posedge clk_wr);
      #1;
      c++;
    end
    if (rx_q.size() < want) begin
      errors++;
      $display("only %0d of %0d beats reached the PHY lanes", rx_q.size(), want);
    end
  endtask

  // Optional credit return for one cycle, then offer the beat
  task automatic send_entry(input int i);
    int n;
    if (tbl[i].ret != '0) begin
      rx_phy0 = LANE_W'(tbl[i].ret);
      step(1);
      rx_phy0 = '0;
    end
    user_tdata  = tbl[i].tdata;
    user_tkeep  = tbl[i].tkeep;
    user_tuser  = tbl[i].tuser;
    user_tvalid = 1'b1;
    n = 0;
    while (!user_tready && n < LIMIT) begin
      step(1);
      n++;
    end
    if (!user_tready) begin
      errors++;
      $display("beat %0d was not accepted within %0d cycles", i, LIMIT);
    end else begin
      step(1);
    end
  endtask

  task automatic send_range(input int first, input int last);
    for (int i = first; i <= last; i++) send_entry(i);
    user_tvalid = 1'b0;
  endtask

  task automatic check_order(input int first, input int count);
    for (int k = 0; k < count && k < rx_q.size(); k++) begin
      check_beat($sformatf("beat %0d", first + k), rx_q[k], expect_beat(first + k));
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int err0;
    int n;
    int last;
    int pulses;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_st_credit = CRED_W'(200);
    tx_mrk_userbit = 2'b00;
    delay_x_value = DELAY_W'(DX);
    delay_y_value = DELAY_W'(DY);
    delay_z_value = DELAY_W'(DZ);
    user_tdata = '0;
    user_tkeep = '0;
    user_tuser = '0;
    user_tvalid = 1'b0;
    rx_phy0 = '0;
    rx_phy1 = '0;
    errors = 0;
    checks = 0;
    seed = 58192;
    // Entry 10 hands back two credits
    for (int i = 0; i < NUM; i++) begin
      tbl[i].tdata = {$random(seed), $random(seed)};
      tbl[i].tkeep = 8'hff >> (i % 4);
      tbl[i].tuser = TUSER_W'(i);
      tbl[i].ret   = (i == 10) ? CRED_RET_W'(2) : '0;
    end
    n = 0;
    while (!rst_n && n < 20) begin
      @(posedge clk_wr);
      n++;
    end
    if (!rst_n) begin
      errors++;
      $display("reset was not released within 20 cycles");
    end
    step(1);

    // Each delay level needs one edge past its count, then the credit load
    err0 = errors;
    check_bit("user_tready", user_tready, 1'b0);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_ready(n);
    check_count("link up cycles", n, DX + DY + 3);
    report_test("online sequence", err0);

    // Strobe every DZ cycles, markers copied to both lanes
    err0 = errors;
    last = -1;
    pulses = 0;
    for (int c = 0; c < 6 * DZ; c++) begin
      step(1);
      if (tx_phy0[STB_BIT]) begin
        if (last >= 0) check_count("stb period", c - last, DZ);
        last = c;
        pulses++;
      end
    end
    check_count("stb pulses", pulses, 6);
    tx_mrk_userbit = 2'b01;
    step(3);
    check_bit("tx_phy0 marker", tx_phy0[MRK_BIT], 1'b1);
    check_bit("tx_phy1 marker", tx_phy1[MRK_BIT], 1'b0);
    tx_mrk_userbit = 2'b10;
    step(3);
    check_bit("tx_phy0 marker", tx_phy0[MRK_BIT], 1'b0);
    check_bit("tx_phy1 marker", tx_phy1[MRK_BIT], 1'b1);
    report_test("strobe and markers", err0);

    // Ample credit, all beats in order
    err0 = errors;
    rx_q.delete();
    send_range(0, 5);
    wait_pushes(6);
    check_count("pushes", rx_q.size(), 6);
    check_order(0, 6);
    report_test("data integrity", err0);

    // Link down and back up with three credits
    err0 = errors;
    tx_online = 1'b0;
    rx_online = 1'b0;
    step(4);
    check_bit("user_tready", user_tready, 1'b0);
    init_st_credit = CRED_W'(3);
    rx_q.delete();
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_ready(n);
    send_range(6, 9);
    wait_pushes(3);
    step(20);
    check_count("pushes at zero credit", rx_q.size(), 3);
    check_bit("user_tready", user_tready, 1'b0);
    check_order(6, 3);
    report_test("credit exhaustion", err0);

    // Two returned credits free the held beat and one more
    err0 = errors;
    send_range(10, 11);
    wait_pushes(5);
    step(20);
    check_count("pushes after return", rx_q.size(), 5);
    check_order(6, 5);
    report_test("credit return", err0);

    errors += uut.u_transmit.u_props.failures;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Whole run limit
  initial begin
    #100000;
    $display("run stopped at its time limit");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: src/link_auto_sync.sv
/* Online delay and strobe generator */

module link_auto_sync #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Raw online levels
  input  logic               tx_online,
  input  logic               rx_online,

  // Delay settings in cycles
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  input  logic [1:0]         tx_mrk_userbit,

  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               stb,
  output logic [1:0]         mrk
);

  //////////////////////////////
  // Online delay counters
  //////////////////////////////

  // Entry 0 is the local side, entry 1 the remote side
  logic [1:0]         dly_src;
  logic [DELAY_W-1:0] dly_lim [2];
  logic [DELAY_W-1:0] dly_cnt [2];
  logic [1:0]         dly_lvl;
  logic [DELAY_W-1:0] per_cnt;

  // Remote delay waits for the local side too
  assign dly_src[0] = tx_online;
  assign dly_src[1] = rx_online & tx_online_delay;
  assign dly_lim[0] = delay_x_value;
  assign dly_lim[1] = delay_y_value;

  // Saturating count while the source holds
  // Level drops one cycle after the source
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dly_cnt[0] <= '0;
      dly_cnt[1] <= '0;
      dly_lvl    <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!dly_src[i]) begin
          dly_cnt[i] <= '0;
          dly_lvl[i] <= 1'b0;
        end else if (dly_cnt[i] >= dly_lim[i]) begin
          dly_lvl[i] <= 1'b1;
        end else begin
          dly_cnt[i] <= dly_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = dly_lvl[0];
  assign rx_online_delay = dly_lvl[1];

  //////////////////////////////
  // Strobe and markers
  //////////////////////////////

  // Period counter, reloaded on every strobe
  // First pulse one full period after going online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt <= '0;
      stb     <= 1'b0;
    end else if (!tx_online_delay) begin
      per_cnt <= delay_z_value;
      stb     <= 1'b0;
    end else if (per_cnt <= DELAY_W'(1)) begin
      per_cnt <= delay_z_value;
      stb     <= 1'b1;
    end else begin
      per_cnt <= per_cnt - 1'b1;
      stb     <= 1'b0;
    end
  end

  // Markers pass through only while online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      mrk <= '0;
    end else begin
      mrk <= tx_online_delay ? tx_mrk_userbit : 2'b00;
    end
  end

endmodule

// File: src/link_transmit.sv
/* Credit based beat transmitter */

module link_transmit #(
  parameter int CRED_W = 8
) (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Delayed online levels
  input  logic                  tx_online_delay,
  input  logic                  rx_online_delay,

  // Credit granted at link up
  input  logic [CRED_W-1:0]     init_st_credit,

  // Beat from the input stage
  input  logic                  beat_valid,
  input  st_link_pkg::st_beat_t beat,
  output logic                  beat_pop,

  // Credit loaded, input stage may accept
  output logic                  link_up,

  link_tx_if.xmit               lnk
);

  import st_link_pkg::*;

  logic              up_now;
  logic              up_q;
  logic              up_rise;
  logic [CRED_W-1:0] credit;
  logic [CRED_W-1:0] cred_add;

  //////////////////////////////
  // Link state
  //////////////////////////////

  // Both sides online and delayed
  assign up_now  = tx_online_delay & rx_online_delay;
  assign up_rise = up_now & ~up_q;

  // Up from the cycle after the credit load
  assign link_up = up_now & up_q;

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  // Returned credit only counts while remote is valid
  assign cred_add = lnk.cred_vld ? CRED_W'(lnk.cred_ret) : '0;

  // Pop needs a beat and at least one credit
  assign beat_pop = link_up & beat_valid & (credit != '0);

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      up_q   <= 1'b0;
      credit <= '0;
    end else begin
      up_q <= up_now;
      if (up_rise) begin
        credit <= init_st_credit;
      end else if (!up_now) begin
        credit <= '0;
      end else begin
        // Spend and refill in the same cycle
        credit <= credit - CRED_W'(beat_pop) + cred_add;
      end
    end
  end

  // Push pulse follows each pop
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      lnk.push <= 1'b0;
    end else begin
      lnk.push <= beat_pop;
    end
  end

  // Popped beat held for the lane mapper
  always_ff @(posedge clk_wr) begin
    if (beat_pop) begin
      lnk.beat <= beat;
    end
  end

endmodule

// File: src/link_tx_if.sv
/* Transmitter to lane mapper link */

interface link_tx_if;

  import st_link_pkg::*;

  // Beat registered on pop
  st_beat_t beat;

  // One-cycle pulse per transmitted beat
  logic push;

  // Credit handed back by the far end
  logic [CRED_RET_W-1:0] cred_ret;

  // Remote side online, cred_ret only counts while high
  logic cred_vld;

  // Credit-counting transmitter side
  modport xmit (
    output beat,
    output push,
    input  cred_ret,
    input  cred_vld
  );

  // PHY lane side
  modport lane (
    input  beat,
    input  push,
    output cred_ret,
    output cred_vld
  );

endinterface

// File: src/phy_lane_map.sv
/* Two lane PHY word mapper */

module phy_lane_map (
  input  logic                            clk_wr,
  input  logic                            rst_n,

  // From the online sync block
  input  logic                            stb,
  input  logic [1:0]                      mrk,
  input  logic                            rx_online_delay,

  // Receive PHY word, carries returned credit
  input  logic [st_link_pkg::LANE_W-1:0]  rx_phy0,

  // Transmit PHY words
  output logic [st_link_pkg::LANE_W-1:0]  tx_phy0,
  output logic [st_link_pkg::LANE_W-1:0]  tx_phy1,

  link_tx_if.lane                         lnk
);

  import st_link_pkg::*;

  logic [LANE_W-1:0] lane0_d;
  logic [LANE_W-1:0] lane1_d;
  logic [2*SLICE_W-1:0] slices;

  //////////////////////////////
  // Transmit lanes
  //////////////////////////////

  // Payload only on push cycles
  assign slices = lnk.push ? lnk.beat : '0;

  // Lane 0: low slice, strobe, marker 0
  always_comb begin
    lane0_d = '0;
    lane0_d[SLICE_W-1:0] = slices[SLICE_W-1:0];
    lane0_d[STB_BIT] = stb;
    lane0_d[MRK_BIT] = mrk[0];
  end

  // Lane 1: high slice, push, marker 1
  always_comb begin
    lane1_d = '0;
    lane1_d[SLICE_W-1:0] = slices[2*SLICE_W-1:SLICE_W];
    lane1_d[PUSH_BIT] = lnk.push;
    lane1_d[MRK_BIT] = mrk[1];
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= lane0_d;
      tx_phy1 <= lane1_d;
    end
  end

  //////////////////////////////
  // Returned credit
  //////////////////////////////

  // Ignore the field while the far end is offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      lnk.cred_ret <= '0;
    end else begin
      lnk.cred_ret <= rx_online_delay ? rx_phy0[CRED_RET_W-1:0] : '0;
    end
  end

  assign lnk.cred_vld = rx_online_delay;

endmodule

// File: src/st_link_pkg.sv
/* Stream link shared definitions */

package st_link_pkg;

  //////////////////////////////
  // Beat payload
  //////////////////////////////

  // Reduced user stream widths
  localparam int TDATA_W = 64;
  localparam int TKEEP_W = 8;
  localparam int TUSER_W = 4;

  // One user beat as it travels through the link
  // MSB first: tuser, tkeep, tdata
  typedef struct packed {
    logic [TUSER_W-1:0] tuser;
    logic [TKEEP_W-1:0] tkeep;
    logic [TDATA_W-1:0] tdata;
  } st_beat_t;

  //////////////////////////////
  // PHY lane layout
  //////////////////////////////

  // Raw PHY word per lane
  localparam int LANE_W = 40;

  // Beat bits per lane, two lanes hold 76 bits
  localparam int SLICE_W = 38;

  // Control bit positions in the lane words
  localparam int MRK_BIT = 39;
  localparam int STB_BIT = 38;
  localparam int PUSH_BIT = 38;

  // Returned credit count, bits 1:0 of rx_phy0
  localparam int CRED_RET_W = 2;

endpackage

// File: src/st_master_top.sv
/* Stream link master top */

module st_master_top #(
  parameter int CRED_W  = 8,
  parameter int DELAY_W = 16
) (
  input  logic                            clk_wr,
  input  logic                            rst_n,

  // Link control
  input  logic                            tx_online,
  input  logic                            rx_online,
  input  logic [CRED_W-1:0]               init_st_credit,
  input  logic [1:0]                      tx_mrk_userbit,
  input  logic [DELAY_W-1:0]              delay_x_value,
  input  logic [DELAY_W-1:0]              delay_y_value,
  input  logic [DELAY_W-1:0]              delay_z_value,

  // User stream
  input  logic [st_link_pkg::TDATA_W-1:0] user_tdata,
  input  logic [st_link_pkg::TKEEP_W-1:0] user_tkeep,
  input  logic [st_link_pkg::TUSER_W-1:0] user_tuser,
  input  logic                            user_tvalid,
  output logic                            user_tready,

  // PHY words, rx_phy1 unused by this master
  output logic [st_link_pkg::LANE_W-1:0]  tx_phy0,
  output logic [st_link_pkg::LANE_W-1:0]  tx_phy1,
  input  logic [st_link_pkg::LANE_W-1:0]  rx_phy0,
  input  logic [st_link_pkg::LANE_W-1:0]  rx_phy1
);

  import st_link_pkg::*;

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       stb;
  logic [1:0] mrk;
  logic       link_up;
  logic       beat_valid;
  logic       beat_pop;
  st_beat_t   beat;

  link_tx_if u_link_if ();

  //////////////////////////////
  // Input stage and sync
  //////////////////////////////

  stream_pack u_stream_pack (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tuser  (user_tuser),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .beat_pop    (beat_pop),
    .beat_valid  (beat_valid),
    .beat        (beat)
  );

  link_auto_sync #(
    .DELAY_W (DELAY_W)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb             (stb),
    .mrk             (mrk)
  );

  //////////////////////////////
  // Transmitter and lanes
  //////////////////////////////

  link_transmit #(
    .CRED_W (CRED_W)
  ) u_transmit (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .init_st_credit  (init_st_credit),
    .beat_valid      (beat_valid),
    .beat            (beat),
    .beat_pop        (beat_pop),
    .link_up         (link_up),
    .lnk             (u_link_if.xmit)
  );

  phy_lane_map u_lane_map (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .stb             (stb),
    .mrk             (mrk),
    .rx_online_delay (rx_online_delay),
    .rx_phy0         (rx_phy0),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .lnk             (u_link_if.lane)
  );

endmodule

// File: src/stream_pack.sv
/* User stream input stage */

module stream_pack (
  input  logic                          clk_wr,
  input  logic                          rst_n,

  // Link has loaded its credit
  input  logic                          link_up,

  // User AXI-stream
  input  logic [st_link_pkg::TDATA_W-1:0] user_tdata,
  input  logic [st_link_pkg::TKEEP_W-1:0] user_tkeep,
  input  logic [st_link_pkg::TUSER_W-1:0] user_tuser,
  input  logic                          user_tvalid,
  output logic                          user_tready,

  // Held beat toward the transmitter
  input  logic                          beat_pop,
  output logic                          beat_valid,
  output st_link_pkg::st_beat_t         beat
);

  import st_link_pkg::*;

  logic accept;

  // Room when empty or draining this cycle
  // Nothing taken before the first link up
  assign user_tready = link_up & (~beat_valid | beat_pop);
  assign accept = user_tready & user_tvalid;

  // Occupancy flag
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      beat_valid <= 1'b0;
    end else if (accept) begin
      beat_valid <= 1'b1;
    end else if (beat_pop) begin
      beat_valid <= 1'b0;
    end
  end

  // Beat register, loaded only on accept
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      beat.tuser <= user_tuser;
      beat.tkeep <= user_tkeep;
      beat.tdata <= user_tdata;
    end
  end

endmodule
